// File: phy_geom_pkg.sv
package phy_geom_pkg;

	// Bus geometry of one full-rate DDR3 I/O block
	localparam int NUM_DQS_GROUPS = 2;
	localparam int GROUP_DQ_WIDTH = 8;
	localparam int AFI_RATE_RATIO = 2;

	// AFI buses are ordered by time slot first, then by DQS group
	localparam int AFI_DATA_WIDTH = GROUP_DQ_WIDTH * NUM_DQS_GROUPS * AFI_RATE_RATIO;
	localparam int AFI_DQS_WIDTH = NUM_DQS_GROUPS * AFI_RATE_RATIO;

	// One DM bit per group per slot
	localparam int AFI_MASK_WIDTH = NUM_DQS_GROUPS * AFI_RATE_RATIO;

	// Write data for all groups and slots of one AFI cycle
	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;

	// Per-slot per-group control, used for write enable, DQS enable and OCT enable
	typedef logic [AFI_DQS_WIDTH-1:0] afi_dqs_t;

	typedef logic [AFI_MASK_WIDTH-1:0] afi_mask_t;

	// One bit per rate slot
	typedef logic [AFI_RATE_RATIO-1:0] afi_rate_t;

	// One bit per DQS group
	typedef logic [NUM_DQS_GROUPS-1:0] group_vec_t;

endpackage

// File: phy_timing_pkg.sv
package phy_timing_pkg;

	// Fixed shift that lines the read enable up with the board round trip
	localparam int EXTRA_VFIFO_SHIFT = 2;

	localparam int RD_LATENCY_WIDTH = 5;
	localparam int VFIFO_INC_WIDTH = 2;

	// Largest latency the sequencer can request
	localparam int MAX_RD_LATENCY = (1 << RD_LATENCY_WIDTH) - 1;

	// Saturation point of the per-group increment counters
	localparam int MAX_VFIFO_INC = 3;

	// Deep enough for the largest latency plus the largest increment
	localparam int LFIFO_DEPTH = MAX_RD_LATENCY + MAX_VFIFO_INC;

	typedef logic [RD_LATENCY_WIDTH-1:0] rd_latency_t;
	typedef logic [VFIFO_INC_WIDTH-1:0] vfifo_inc_t;

endpackage

// File: afi_write_if.sv
`timescale 1ns/1ps

// Registered AFI write bundle, still in slot-major order
interface afi_write_if;

	phy_geom_pkg::afi_data_t dq;
	phy_geom_pkg::afi_dqs_t wrdata_en;
	phy_geom_pkg::afi_mask_t wrdata_mask;
	phy_geom_pkg::afi_dqs_t dqs_en;
	phy_geom_pkg::afi_dqs_t oct_ena;

	modport source (
		output dq,
		output wrdata_en,
		output wrdata_mask,
		output dqs_en,
		output oct_ena
	);

	modport sink (
		input dq,
		input wrdata_en,
		input wrdata_mask,
		input dqs_en,
		input oct_ena
	);

endinterface

// File: write_c2p_stage.sv
`timescale 1ns/1ps

module write_c2p_stage (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input phy_geom_pkg::afi_data_t phy_ddio_dq,
	input phy_geom_pkg::afi_dqs_t phy_ddio_wrdata_en,
	input phy_geom_pkg::afi_mask_t phy_ddio_wrdata_mask,
	input phy_geom_pkg::afi_dqs_t phy_ddio_dqs_en,
	input phy_geom_pkg::afi_dqs_t phy_ddio_oct_ena,
	afi_write_if.source wr
);

	// The core only has to close timing to this flop at the core to periphery boundary
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			wr.dq <= '0;
			wr.wrdata_en <= '0;
			wr.wrdata_mask <= '0;
			wr.dqs_en <= '0;
			wr.oct_ena <= '0;
		end else begin
			wr.dq <= phy_ddio_dq;
			wr.wrdata_en <= phy_ddio_wrdata_en;
			wr.wrdata_mask <= phy_ddio_wrdata_mask;
			wr.dqs_en <= phy_ddio_dqs_en;
			wr.oct_ena <= phy_ddio_oct_ena;
		end
	end

endmodule

// File: dqs_group_slicer.sv
`timescale 1ns/1ps

module dqs_group_slicer (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	afi_write_if.sink wr,
	output phy_geom_pkg::afi_data_t group_dq,
	output phy_geom_pkg::afi_dqs_t group_dq_oe,
	output phy_geom_pkg::afi_mask_t group_dm,
	output phy_geom_pkg::afi_dqs_t group_dqs_oe,
	output phy_geom_pkg::afi_dqs_t group_oct_ena
);

	// Input lane t*G+g moves to output lane g*R+t, so every group sees its slots side by side
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			group_dq <= '0;
			group_dq_oe <= '0;
			group_dm <= '0;
			group_dqs_oe <= '0;
			group_oct_ena <= '0;
		end else begin
			for (int g = 0; g < phy_geom_pkg::NUM_DQS_GROUPS; g++) begin
				for (int t = 0; t < phy_geom_pkg::AFI_RATE_RATIO; t++) begin
					group_dq[(g * phy_geom_pkg::AFI_RATE_RATIO + t) *
						phy_geom_pkg::GROUP_DQ_WIDTH +: phy_geom_pkg::GROUP_DQ_WIDTH] <=
						wr.dq[(t * phy_geom_pkg::NUM_DQS_GROUPS + g) *
						phy_geom_pkg::GROUP_DQ_WIDTH +: phy_geom_pkg::GROUP_DQ_WIDTH];
					group_dq_oe[g * phy_geom_pkg::AFI_RATE_RATIO + t] <=
						wr.wrdata_en[t * phy_geom_pkg::NUM_DQS_GROUPS + g];
					group_dm[g * phy_geom_pkg::AFI_RATE_RATIO + t] <=
						wr.wrdata_mask[t * phy_geom_pkg::NUM_DQS_GROUPS + g];
					group_dqs_oe[g * phy_geom_pkg::AFI_RATE_RATIO + t] <=
						wr.dqs_en[t * phy_geom_pkg::NUM_DQS_GROUPS + g];
					group_oct_ena[g * phy_geom_pkg::AFI_RATE_RATIO + t] <=
						wr.oct_ena[t * phy_geom_pkg::NUM_DQS_GROUPS + g];
				end
			end
		end
	end

endmodule

// File: vfifo_shift.sv
`timescale 1ns/1ps

module vfifo_shift (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic rden,
	output logic rden_shifted
);

	logic [phy_timing_pkg::EXTRA_VFIFO_SHIFT-1:0] shift_q;

	// Strobe enters at bit 0 and leaves from the top bit
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			shift_q <= '0;
		end else begin
			shift_q <= {shift_q[phy_timing_pkg::EXTRA_VFIFO_SHIFT-2:0], rden};
		end
	end

	assign rden_shifted = shift_q[phy_timing_pkg::EXTRA_VFIFO_SHIFT-1];

endmodule

// File: read_latency_fifo.sv
`timescale 1ns/1ps

module read_latency_fifo (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic rden_shifted,
	input phy_timing_pkg::rd_latency_t rd_latency,
	input phy_geom_pkg::group_vec_t vfifo_inc,
	input logic fifo_reset,
	output phy_geom_pkg::group_vec_t group_valid
);

	for (genvar g = 0; g < phy_geom_pkg::NUM_DQS_GROUPS; g++) begin : gen_group
		logic [phy_timing_pkg::LFIFO_DEPTH-1:0] dly_q;
		phy_timing_pkg::vfifo_inc_t inc_cnt;
		int unsigned tap;
		logic tap_valid;

		// Every strobe walks the whole line so several reads can be in flight
		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
			if (!reset_n_afi_clk) begin
				dly_q <= '0;
			end else begin
				dly_q <= {dly_q[phy_timing_pkg::LFIFO_DEPTH-2:0], rden_shifted};
			end
		end

		// Sequencer nudges this group's read point later, one cycle per pulse
		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
			if (!reset_n_afi_clk) begin
				inc_cnt <= '0;
			end else if (fifo_reset) begin
				inc_cnt <= '0;
			end else if (vfifo_inc[g] &&
				inc_cnt != phy_timing_pkg::vfifo_inc_t'(phy_timing_pkg::MAX_VFIFO_INC)) begin
				inc_cnt <= inc_cnt + 1'b1;
			end
		end

		// Tap L-1 of the line is L registers after the input
		always_comb begin
			tap = int'(rd_latency) + int'(inc_cnt);
			if (tap != 0) begin
				tap_valid = dly_q[tap - 1];
			end else begin
				tap_valid = 1'b0;
			end
		end

		assign group_valid[g] = tap_valid;
	end

	// Zero latency would need a combinational path from the strobe
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		rd_latency != '0)
	else
		$error("Read latency of zero while out of reset");

endmodule

// File: rdata_valid_merge.sv
`timescale 1ns/1ps

module rdata_valid_merge (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input phy_geom_pkg::group_vec_t group_valid,
	output phy_geom_pkg::afi_rate_t afi_rdata_valid
);

	// Read data counts as valid only once every group has it
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			afi_rdata_valid <= '0;
		end else begin
			afi_rdata_valid <= {phy_geom_pkg::AFI_RATE_RATIO{&group_valid}};
		end
	end

endmodule

// File: ddr_io_datapath.sv
`timescale 1ns/1ps

module ddr_io_datapath (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input phy_geom_pkg::afi_data_t phy_ddio_dq,
	input phy_geom_pkg::afi_dqs_t phy_ddio_wrdata_en,
	input phy_geom_pkg::afi_mask_t phy_ddio_wrdata_mask,
	input phy_geom_pkg::afi_dqs_t phy_ddio_dqs_en,
	input phy_geom_pkg::afi_dqs_t phy_ddio_oct_ena,
	input phy_geom_pkg::afi_rate_t afi_rdata_en_full,
	input phy_timing_pkg::rd_latency_t seq_read_latency_counter,
	input phy_geom_pkg::group_vec_t seq_read_increment_vfifo_fr,
	input logic seq_read_fifo_reset,
	output phy_geom_pkg::afi_data_t group_dq,
	output phy_geom_pkg::afi_dqs_t group_dq_oe,
	output phy_geom_pkg::afi_mask_t group_dm,
	output phy_geom_pkg::afi_dqs_t group_dqs_oe,
	output phy_geom_pkg::afi_dqs_t group_oct_ena,
	output phy_geom_pkg::afi_rate_t afi_rdata_valid
);

	logic rden_shifted;
	phy_geom_pkg::group_vec_t group_valid;

	afi_write_if wr_if ();

	write_c2p_stage c2p_i (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.phy_ddio_dq (phy_ddio_dq),
		.phy_ddio_wrdata_en (phy_ddio_wrdata_en),
		.phy_ddio_wrdata_mask (phy_ddio_wrdata_mask),
		.phy_ddio_dqs_en (phy_ddio_dqs_en),
		.phy_ddio_oct_ena (phy_ddio_oct_ena),
		.wr (wr_if.source)
	);

	dqs_group_slicer slicer_i (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.wr (wr_if.sink),
		.group_dq (group_dq),
		.group_dq_oe (group_dq_oe),
		.group_dm (group_dm),
		.group_dqs_oe (group_dqs_oe),
		.group_oct_ena (group_oct_ena)
	);

	// In full rate both slots carry the same read enable, slot 0 stands for them
	vfifo_shift vfifo_i (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rden (afi_rdata_en_full[0]),
		.rden_shifted (rden_shifted)
	);

	read_latency_fifo lfifo_i (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rden_shifted (rden_shifted),
		.rd_latency (seq_read_latency_counter),
		.vfifo_inc (seq_read_increment_vfifo_fr),
		.fifo_reset (seq_read_fifo_reset),
		.group_valid (group_valid)
	);

	rdata_valid_merge merge_i (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.group_valid (group_valid),
		.afi_rdata_valid (afi_rdata_valid)
	);

endmodule

// File: tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Slot-major lane t*G+g of the AFI bus lands in group-major lane g*R+t
function automatic phy_geom_pkg::afi_data_t transpose_dq(input phy_geom_pkg::afi_data_t d);
	phy_geom_pkg::afi_data_t r;
	int src;
	int dst;
	r = '0;
	for (int g = 0; g < phy_geom_pkg::NUM_DQS_GROUPS; g++) begin
		for (int t = 0; t < phy_geom_pkg::AFI_RATE_RATIO; t++) begin
			src = t * phy_geom_pkg::NUM_DQS_GROUPS + g;
			dst = g * phy_geom_pkg::AFI_RATE_RATIO + t;
			r[dst * phy_geom_pkg::GROUP_DQ_WIDTH +: phy_geom_pkg::GROUP_DQ_WIDTH] =
				d[src * phy_geom_pkg::GROUP_DQ_WIDTH +: phy_geom_pkg::GROUP_DQ_WIDTH];
		end
	end
	return r;
endfunction

// Same reordering for the one-bit-per-lane control and mask fields
function automatic phy_geom_pkg::afi_dqs_t transpose_lanes(input phy_geom_pkg::afi_dqs_t b);
	phy_geom_pkg::afi_dqs_t r;
	r = '0;
	for (int g = 0; g < phy_geom_pkg::NUM_DQS_GROUPS; g++) begin
		for (int t = 0; t < phy_geom_pkg::AFI_RATE_RATIO; t++) begin
			r[g * phy_geom_pkg::AFI_RATE_RATIO + t] = b[t * phy_geom_pkg::NUM_DQS_GROUPS + g];
		end
	end
	return r;
endfunction

// Increment count after one clock, saturating and cleared by the FIFO reset
function automatic int next_inc_count(input int cnt, input logic inc, input logic clr);
	if (clr) begin
		return 0;
	end
	if (inc && cnt < phy_timing_pkg::MAX_VFIFO_INC) begin
		return cnt + 1;
	end
	return cnt;
endfunction

// A strobe seen at cycle i reaches the group tap after the VFIFO shift and the group latency
function automatic logic group_valid_ref(input int m, input int g);
	int tap;
	int idx;
	tap = tot_lat_hist[g][m];
	idx = m - phy_timing_pkg::EXTRA_VFIFO_SHIFT - tap;
	if (tap == 0 || idx < 0) begin
		return 1'b0;
	end
	return rden_hist[idx];
endfunction

// The merge stage adds one more cycle and needs all groups to agree
function automatic phy_geom_pkg::afi_rate_t expected_valid(input int n);
	logic all_valid;
	if (n < 1) begin
		return '0;
	end
	all_valid = 1'b1;
	for (int g = 0; g < phy_geom_pkg::NUM_DQS_GROUPS; g++) begin
		all_valid = all_valid & group_valid_ref(n - 1, g);
	end
	return {phy_geom_pkg::AFI_RATE_RATIO{all_valid}};
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	if (actual !== expected) begin
		error_count = error_count + 1;
		$display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
		$display("Regression failed");
		$fatal(1, "Stopping at the first mismatch");
	end
endtask

`endif

// File: tb_ddr_io_datapath.sv
`timescale 1ns/1ps

module tb_ddr_io_datapath;

	localparam int RST_CYCLES = 10;
	localparam int IDLE_CYCLES = 5;
	localparam int WRITE_CYCLES = 200;
	localparam int BURST_LEN = 40;
	localparam int DRAIN_CYCLES = 40;
	localparam int NUM_BURSTS = 4;
	// Each read phase fits in one burst plus one drain and four extra phases cover the rest
	localparam int TEST_CYCLES = RST_CYCLES + IDLE_CYCLES + WRITE_CYCLES +
		(NUM_BURSTS + 4) * (BURST_LEN + DRAIN_CYCLES) + 20;
	localparam int TIMEOUT_LIMIT = TEST_CYCLES + phy_timing_pkg::LFIFO_DEPTH + 20;
	localparam int HIST_LEN = TIMEOUT_LIMIT + 8;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	phy_geom_pkg::afi_data_t phy_ddio_dq;
	phy_geom_pkg::afi_dqs_t phy_ddio_wrdata_en;
	phy_geom_pkg::afi_mask_t phy_ddio_wrdata_mask;
	phy_geom_pkg::afi_dqs_t phy_ddio_dqs_en;
	phy_geom_pkg::afi_dqs_t phy_ddio_oct_ena;
	phy_geom_pkg::afi_rate_t afi_rdata_en_full;
	phy_timing_pkg::rd_latency_t seq_read_latency_counter;
	phy_geom_pkg::group_vec_t seq_read_increment_vfifo_fr;
	logic seq_read_fifo_reset;
	phy_geom_pkg::afi_data_t group_dq;
	phy_geom_pkg::afi_dqs_t group_dq_oe;
	phy_geom_pkg::afi_mask_t group_dm;
	phy_geom_pkg::afi_dqs_t group_dqs_oe;
	phy_geom_pkg::afi_dqs_t group_oct_ena;
	phy_geom_pkg::afi_rate_t afi_rdata_valid;

	integer seed;
	int error_count;
	int cycle_cnt;
	int hist_idx;
	phy_timing_pkg::rd_latency_t cur_latency;

	// Input history, one entry per falling edge
	phy_geom_pkg::afi_data_t dq_hist [HIST_LEN];
	phy_geom_pkg::afi_dqs_t wrdata_en_hist [HIST_LEN];
	phy_geom_pkg::afi_mask_t mask_hist [HIST_LEN];
	phy_geom_pkg::afi_dqs_t dqs_en_hist [HIST_LEN];
	phy_geom_pkg::afi_dqs_t oct_hist [HIST_LEN];
	logic rden_hist [HIST_LEN];
	int tot_lat_hist [phy_geom_pkg::NUM_DQS_GROUPS][HIST_LEN];
	int inc_model [phy_geom_pkg::NUM_DQS_GROUPS];
	phy_geom_pkg::group_vec_t inc_prev;
	logic fifo_reset_prev;

	`include "tb_ref_model.svh"

	ddr_io_datapath dut_i (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.phy_ddio_dq (phy_ddio_dq),
		.phy_ddio_wrdata_en (phy_ddio_wrdata_en),
		.phy_ddio_wrdata_mask (phy_ddio_wrdata_mask),
		.phy_ddio_dqs_en (phy_ddio_dqs_en),
		.phy_ddio_oct_ena (phy_ddio_oct_ena),
		.afi_rdata_en_full (afi_rdata_en_full),
		.seq_read_latency_counter (seq_read_latency_counter),
		.seq_read_increment_vfifo_fr (seq_read_increment_vfifo_fr),
		.seq_read_fifo_reset (seq_read_fifo_reset),
		.group_dq (group_dq),
		.group_dq_oe (group_dq_oe),
		.group_dm (group_dm),
		.group_dqs_oe (group_dqs_oe),
		.group_oct_ena (group_oct_ena),
		.afi_rdata_valid (afi_rdata_valid)
	);

	always #2 pll_afi_clk = ~pll_afi_clk;

	always @(posedge pll_afi_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_LIMIT) begin
			$display("Timeout: the test did not finish within %0d cycles", TIMEOUT_LIMIT);
			$display("Regression failed");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	// Outputs are stable at the falling edge, halfway between input updates
	always @(negedge pll_afi_clk) begin
		for (int g = 0; g < phy_geom_pkg::NUM_DQS_GROUPS; g++) begin
			inc_model[g] = next_inc_count(inc_model[g], inc_prev[g],
				fifo_reset_prev || !reset_n_afi_clk);
			tot_lat_hist[g][hist_idx] = int'(seq_read_latency_counter) + inc_model[g];
		end
		// A write stage held in reset takes zero instead of its input
		dq_hist[hist_idx] = reset_n_afi_clk ? phy_ddio_dq : '0;
		wrdata_en_hist[hist_idx] = reset_n_afi_clk ? phy_ddio_wrdata_en : '0;
		mask_hist[hist_idx] = reset_n_afi_clk ? phy_ddio_wrdata_mask : '0;
		dqs_en_hist[hist_idx] = reset_n_afi_clk ? phy_ddio_dqs_en : '0;
		oct_hist[hist_idx] = reset_n_afi_clk ? phy_ddio_oct_ena : '0;
		rden_hist[hist_idx] = afi_rdata_en_full[0];
		inc_prev = seq_read_increment_vfifo_fr;
		fifo_reset_prev = seq_read_fifo_reset;
		if (reset_n_afi_clk && hist_idx >= 2) begin
			check_value("group_dq", transpose_dq(dq_hist[hist_idx-2]), group_dq);
			check_value("group_dq_oe", transpose_lanes(wrdata_en_hist[hist_idx-2]), group_dq_oe);
			check_value("group_dm", transpose_lanes(mask_hist[hist_idx-2]), group_dm);
			check_value("group_dqs_oe", transpose_lanes(dqs_en_hist[hist_idx-2]), group_dqs_oe);
			check_value("group_oct_ena", transpose_lanes(oct_hist[hist_idx-2]), group_oct_ena);
			check_value("afi_rdata_valid", expected_valid(hist_idx), afi_rdata_valid);
		end
		hist_idx = hist_idx + 1;
	end

	task automatic drive_cycle(input bit rand_wr, input bit rden,
		input phy_geom_pkg::group_vec_t inc, input bit lfifo_rst);
		@(posedge pll_afi_clk);
		if (rand_wr) begin
			phy_ddio_dq <= $random(seed);
			phy_ddio_wrdata_en <= phy_geom_pkg::afi_dqs_t'($random(seed));
			phy_ddio_wrdata_mask <= phy_geom_pkg::afi_mask_t'($random(seed));
			phy_ddio_dqs_en <= phy_geom_pkg::afi_dqs_t'($random(seed));
			phy_ddio_oct_ena <= phy_geom_pkg::afi_dqs_t'($random(seed));
		end else begin
			phy_ddio_dq <= '0;
			phy_ddio_wrdata_en <= '0;
			phy_ddio_wrdata_mask <= '0;
			phy_ddio_dqs_en <= '0;
			phy_ddio_oct_ena <= '0;
		end
		afi_rdata_en_full <= {phy_geom_pkg::AFI_RATE_RATIO{rden}};
		seq_read_increment_vfifo_fr <= inc;
		seq_read_fifo_reset <= lfifo_rst;
		seq_read_latency_counter <= cur_latency;
	endtask

	task automatic idle_cycles(input int n, input bit rand_wr);
		repeat (n) drive_cycle(rand_wr, 1'b0, '0, 1'b0);
	endtask

	task automatic run_read_burst(input int len);
		logic [31:0] rnd;
		repeat (len) begin
			rnd = $random(seed);
			drive_cycle(1'b1, rnd[0], '0, 1'b0);
		end
	endtask

	// One isolated strobe, then count cycles until the valid pulse shows up
	task automatic measure_read_delay(input int expected);
		int delay;
		delay = 0;
		drive_cycle(1'b1, 1'b1, '0, 1'b0);
		do begin
			drive_cycle(1'b1, 1'b0, '0, 1'b0);
			delay++;
			@(negedge pll_afi_clk);
		end while (afi_rdata_valid == '0 && delay < DRAIN_CYCLES);
		check_value("afi_rdata_valid delay", expected, delay);
		check_value("afi_rdata_valid", {phy_geom_pkg::AFI_RATE_RATIO{1'b1}}, afi_rdata_valid);
		drive_cycle(1'b1, 1'b0, '0, 1'b0);
		@(negedge pll_afi_clk);
		check_value("afi_rdata_valid", '0, afi_rdata_valid);
	endtask

	initial begin
		seed = 32'h2f70;
		error_count = 0;
		cycle_cnt = 0;
		hist_idx = 0;
		cur_latency = 5;
		inc_prev = '0;
		fifo_reset_prev = 1'b0;
		for (int g = 0; g < phy_geom_pkg::NUM_DQS_GROUPS; g++) begin
			inc_model[g] = 0;
		end
		pll_afi_clk = 1'b0;
		reset_n_afi_clk = 1'b0;
		// Write inputs sit at all ones so only the reset can hold the outputs at zero
		phy_ddio_dq = '1;
		phy_ddio_wrdata_en = '1;
		phy_ddio_wrdata_mask = '1;
		phy_ddio_dqs_en = '1;
		phy_ddio_oct_ena = '1;
		afi_rdata_en_full = '0;
		seq_read_latency_counter = cur_latency;
		seq_read_increment_vfifo_fr = '0;
		seq_read_fifo_reset = 1'b0;

		repeat (RST_CYCLES) @(posedge pll_afi_clk);
		reset_n_afi_clk <= 1'b1;

		@(negedge pll_afi_clk);
		check_value("group_dq", '0, group_dq);
		check_value("group_dq_oe", '0, group_dq_oe);
		check_value("group_dm", '0, group_dm);
		check_value("group_dqs_oe", '0, group_dqs_oe);
		check_value("group_oct_ena", '0, group_oct_ena);
		check_value("afi_rdata_valid", '0, afi_rdata_valid);
		idle_cycles(IDLE_CYCLES, 1'b0);

		idle_cycles(WRITE_CYCLES, 1'b1);

		measure_read_delay(phy_timing_pkg::EXTRA_VFIFO_SHIFT + 5 + 1);
		idle_cycles(DRAIN_CYCLES, 1'b1);

		// Latency only changes once the previous burst has drained
		repeat (NUM_BURSTS) begin
			cur_latency = phy_timing_pkg::rd_latency_t'(1 + ({$random(seed)} % 31));
			run_read_burst(BURST_LEN);
			idle_cycles(DRAIN_CYCLES, 1'b1);
		end

		// Group 1 two cycles behind group 0
		cur_latency = 6;
		drive_cycle(1'b1, 1'b0, 2'b10, 1'b0);
		drive_cycle(1'b1, 1'b0, 2'b10, 1'b0);
		run_read_burst(BURST_LEN);
		idle_cycles(DRAIN_CYCLES, 1'b1);

		repeat (3) drive_cycle(1'b1, 1'b0, 2'b10, 1'b0);
		run_read_burst(BURST_LEN);
		idle_cycles(DRAIN_CYCLES, 1'b1);

		drive_cycle(1'b1, 1'b0, '0, 1'b1);
		measure_read_delay(phy_timing_pkg::EXTRA_VFIFO_SHIFT + 6 + 1);
		idle_cycles(DRAIN_CYCLES, 1'b1);

		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+.
phy_geom_pkg.sv
phy_timing_pkg.sv
afi_write_if.sv
write_c2p_stage.sv
dqs_group_slicer.sv
vfifo_shift.sv
read_latency_fifo.sv
rdata_valid_merge.sv
ddr_io_datapath.sv
tb_ddr_io_datapath.sv

// File: Bender.yml
package:
  name: ddr_io_datapath

sources:
  - files:
      - phy_geom_pkg.sv
      - phy_timing_pkg.sv
      - afi_write_if.sv
      - write_c2p_stage.sv
      - dqs_group_slicer.sv
      - vfifo_shift.sv
      - read_latency_fifo.sv
      - rdata_valid_merge.sv
      - ddr_io_datapath.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ddr_io_datapath.sv
